// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert --timescale 1ns/1ns
TOP    = tbRvCore
FLIST  = list.f
OBJDIR = obj_dir
LOG    = sim.log
BIN    = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: list.f
+incdir+verilog
verilog/rvTypes.sv
verilog/instrDecoder.sv
verilog/intAlu.sv
verilog/regFile.sv
verilog/pcUnit.sv
verilog/rvCore.sv
verif/tbRvCore.sv

// File: verif/tbRvCore.sv
`default_nettype none
`timescale 1ns/1ns
`include "rvCore_cfg.svh"

module tbRvCore;

    localparam int numReset   = 31;
    localparam int numArith   = 300;
    localparam int numX0      = 8;
    localparam int numUpper   = 40;
    localparam int numBranch  = 60;
    localparam int numIllegal = 12;
    localparam int numMixed   = 60;
    localparam int cycleLimit = 2 * (numReset + numArith + numX0 + numUpper + numBranch
                                     + numIllegal + numMixed) + 100;

    logic                           clk;
    logic                           rstN;
    logic                           instrValid;
    rvTypes::Instruction            instr;
    logic [31:0]                    pc;
    logic                           retireValid;
    rvTypes::RetireInfo             retire;
    logic [`RV_REG_COUNT-1:0][31:0] modelRegs;
    logic [31:0]                    modelPc;
    logic [31:0]                    expPc;         // pc the DUT should show now
    logic                           expectRetire;  // instrValid seen one cycle back
    logic [15:0]                    lfsr;
    rvTypes::RetireInfo             expQ [$];
    int                             checkCount;
    int                             errorCount;
    int                             testChecks;
    int                             testErrors;
    int                             cycleCount;

    rvCore u_dut (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .pc(pc), .retireValid(retireValid), .retire(retire)
    );

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // kind 0 arith, 1 upper or jump, 2 branch, 3 illegal
    function automatic rvTypes::Instruction genInstr(input int kind);
        rvTypes::Instruction ins;
        logic [1:0]          sel;
        ins          = rvTypes::Instruction'(randBits(32));
        ins.always11 = 2'b11;
        sel          = 2'(randBits(2));
        case (kind)
            0: begin
                ins.opCode = sel[0] ? rvTypes::OP : rvTypes::OP_IMM;
                if (sel[0] || ins.funct3 inside {3'd1, 3'd5}) begin
                    ins.funct7 = {1'b0, ins.funct7[5] && ins.funct3 inside {3'd0, 3'd5}, 5'd0};
                end
            end
            1: begin
                case (sel)
                    2'd0: ins.opCode = rvTypes::LUI;
                    2'd1: ins.opCode = rvTypes::AUIPC;
                    2'd2: ins.opCode = rvTypes::JAL;
                    default: begin
                        ins.opCode = rvTypes::JALR;
                        ins.funct3 = 3'd0;
                    end
                endcase
            end
            2: begin
                ins.opCode = rvTypes::BRANCH;
                if (ins.funct3 inside {3'd2, 3'd3}) begin
                    ins.funct3 = ins.funct3 + 3'd4;  // no branch on 010/011
                end
                if (sel[0]) begin
                    ins.rs2 = ins.rs1;  // equal operands now and then
                end
            end
            default: ins.opCode = sel[0] ? rvTypes::LOAD : (sel[1] ? rvTypes::STORE : rvTypes::SYSTEM);
        endcase
        return ins;
    endfunction

    function automatic rvTypes::RetireInfo rvModelStep(
        inout logic [`RV_REG_COUNT-1:0][31:0] regs,
        inout logic [31:0]                    pcNow,
        input rvTypes::Instruction            ins
    );
        rvTypes::RetireInfo r;
        logic [31:0]        w;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        opB;
        logic [31:0]        immI;
        logic [31:0]        target;
        logic               taken;
        w        = ins;
        a        = regs[w[19:15]];
        b        = regs[w[24:20]];
        immI     = {{20{w[31]}}, w[31:20]};
        opB      = (ins.opCode == rvTypes::OP) ? b : immI;
        r        = '0;
        r.pc     = pcNow;
        r.instr  = ins;
        r.wbAddr = w[11:7];
        target   = pcNow + 32'd4;
        taken    = 1'b0;
        case (ins.opCode)
            rvTypes::OP, rvTypes::OP_IMM: begin
                case (w[14:12])
                    3'd0: r.wbData = (ins.opCode == rvTypes::OP && w[30]) ? a - opB : a + opB;
                    3'd1: r.wbData = a << opB[4:0];
                    3'd2: r.wbData = {31'd0, $signed(a) < $signed(opB)};
                    3'd3: r.wbData = {31'd0, a < opB};
                    3'd4: r.wbData = a ^ opB;
                    3'd5: r.wbData = w[30] ? $unsigned($signed(a) >>> opB[4:0]) : a >> opB[4:0];
                    3'd6: r.wbData = a | opB;
                    default: r.wbData = a & opB;
                endcase
            end
            rvTypes::LUI:   r.wbData = {w[31:12], 12'd0};
            rvTypes::AUIPC: r.wbData = pcNow + {w[31:12], 12'd0};
            rvTypes::JAL: begin
                r.wbData = pcNow + 32'd4;
                target   = pcNow + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            rvTypes::JALR: begin
                r.wbData = pcNow + 32'd4;
                target   = a + immI;
            end
            rvTypes::BRANCH: begin
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    target = pcNow + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: r.illegal = 1'b1;  // load, store, system
        endcase
        r.wbEn   = !r.illegal && ins.opCode != rvTypes::BRANCH && w[11:7] != 5'd0;
        r.nextPc = {target[31:2], 2'b00};
        if (r.wbEn) begin
            regs[w[11:7]] = r.wbData;
        end
        pcNow = r.nextPc;
        return r;
    endfunction

    task automatic checkRetire(input rvTypes::RetireInfo got, input rvTypes::RetireInfo exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t ns: retire record at pc %h, got %h, expected %h",
                     $time, exp.pc, got, exp);
        end
    endtask

    task automatic checkPc(input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t ns: pc is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic sendInstr(input rvTypes::Instruction ins);
        expQ.push_back(rvModelStep(modelRegs, modelPc, ins));
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= ins;
    endtask

    task automatic sendBubble();
        @(posedge clk);
        instrValid <= 1'b0;
        instr      <= rvTypes::Instruction'(randBits(32));  // junk the core must ignore
    endtask

    task automatic finishTest(input int num, input string name);
        sendBubble();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checkCount - testChecks, errorCount - testErrors);
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    always @(negedge clk) begin : compareRetire
        rvTypes::RetireInfo exp;
        if (rstN) begin
            if (retireValid && !expectRetire) begin
                errorCount++;
                $display("Error at %0t ns: retirement without an accepted instruction", $time);
            end else if (!retireValid && expectRetire) begin
                errorCount++;
                $display("Error at %0t ns: accepted instruction did not retire", $time);
                if (expQ.size() != 0) begin
                    exp   = expQ.pop_front();
                    expPc = exp.nextPc;
                end
            end
            if (retireValid) begin
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("Error at %0t ns: retirement with nothing left to expect", $time);
                end else begin
                    exp = expQ.pop_front();
                    checkRetire(retire, exp);
                    expPc = exp.nextPc;
                end
            end
            checkPc(pc, expPc);
        end
        expectRetire = instrValid;  // sampled at the next rising edge
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run stopped after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        instrValid   = 1'b0;
        instr        = '0;
        modelRegs    = '0;
        modelPc      = `RV_RESET_PC;
        expPc        = `RV_RESET_PC;
        expectRetire = 1'b0;
        lfsr         = 16'd54331;
        checkCount   = 0;
        errorCount   = 0;
        testChecks   = 0;
        testErrors   = 0;
        cycleCount   = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkRetire(retire, '0);  // record cleared by reset
        for (int i = 1; i <= numReset; i++) begin
            sendInstr({7'd0, 5'(32 - i), 5'(i), 3'd6, 5'(i), rvTypes::OP, 2'b11});
        end
        finishTest(1, "reset");
        repeat (numArith) sendInstr(genInstr(0));
        for (int i = 1; i <= numX0 / 2; i++) begin
            sendInstr({7'h3f, 5'h1f, 5'(i), 3'd0, 5'd0, rvTypes::OP_IMM, 2'b11});  // addi x0
            sendInstr({7'd0, 5'd0, 5'd0, 3'd0, 5'(i), rvTypes::OP, 2'b11});  // reads x0 twice
        end
        finishTest(2, "register arithmetic");
        repeat (numUpper) sendInstr(genInstr(1));
        finishTest(3, "upper immediates and jumps");
        repeat (numBranch) sendInstr(genInstr(2));
        finishTest(4, "branches");
        repeat (numIllegal) sendInstr(genInstr(3));
        finishTest(5, "illegal opcodes");
        repeat (numMixed) begin
            repeat (randBits(2)) sendBubble();
            sendInstr(genInstr(int'(randBits(1)) * 2));
        end
        finishTest(6, "bubbles");
        $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
`default_nettype none
`timescale 1ns/1ns

module instrDecoder (
    input  wire rvTypes::Instruction instr,
    output rvTypes::DecodedInstr     dec
);

    logic sign;

    assign sign = instr.funct7[6];  // instruction bit 31

    always_comb begin
        dec            = '0;
        dec.opCode     = instr.opCode;
        dec.rs1        = instr.rs1;
        dec.rs2        = instr.rs2;
        dec.rd         = instr.rd;
        dec.useImm     = (instr.opCode == rvTypes::OP_IMM);
        dec.branchCond = rvTypes::BranchCond'(instr.funct3);

        // immediate by format
        case (instr.opCode)
            rvTypes::STORE:
                dec.imm = {{20{sign}}, instr.funct7, instr.rd};
            rvTypes::BRANCH:
                dec.imm = {{19{sign}}, sign, instr.rd[0], instr.funct7[5:0],
                           instr.rd[4:1], 1'b0};
            rvTypes::LUI, rvTypes::AUIPC:
                dec.imm = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'h000};
            rvTypes::JAL:
                dec.imm = {{11{sign}}, sign, instr.rs1, instr.funct3, instr.rs2[0],
                           instr.funct7[5:0], instr.rs2[4:1], 1'b0};
            default:
                dec.imm = {{20{sign}}, instr.funct7, instr.rs2};  // I-type
        endcase

        if (instr.opCode == rvTypes::OP || instr.opCode == rvTypes::OP_IMM) begin
            case (instr.funct3)
                3'b000: begin
                    // no SUBI, so funct7 only counts for OP
                    if (instr.opCode == rvTypes::OP && instr.funct7[5]) begin
                        dec.aluCmd = rvTypes::ALU_SUB;
                    end else begin
                        dec.aluCmd = rvTypes::ALU_ADD;
                    end
                end
                3'b001:  dec.aluCmd = rvTypes::ALU_SLL;
                3'b010:  dec.aluCmd = rvTypes::ALU_SLT;
                3'b011:  dec.aluCmd = rvTypes::ALU_SLTU;
                3'b100:  dec.aluCmd = rvTypes::ALU_XOR;
                3'b101:  dec.aluCmd = instr.funct7[5] ? rvTypes::ALU_SRA : rvTypes::ALU_SRL;
                3'b110:  dec.aluCmd = rvTypes::ALU_OR;
                default: dec.aluCmd = rvTypes::ALU_AND;
            endcase
        end else begin
            dec.aluCmd = rvTypes::ALU_ADD;  // unused outside OP / OP_IMM
        end

        case (instr.opCode)
            rvTypes::OP_IMM, rvTypes::OP, rvTypes::LUI, rvTypes::AUIPC,
            rvTypes::BRANCH, rvTypes::JAL, rvTypes::JALR:
                dec.illegal = 1'b0;
            default:
                dec.illegal = 1'b1;  // load, store, system and unknown
        endcase

        dec.wbEn = !dec.illegal && (instr.opCode != rvTypes::BRANCH) && (instr.rd != '0);
    end

endmodule

`default_nettype wire

// File: verilog/intAlu.sv
`default_nettype none
`timescale 1ns/1ns

module intAlu (
    input  wire rvTypes::AluCmd cmd,
    input  wire logic [31:0]    a,
    input  wire logic [31:0]    b,
    output logic [31:0]         result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (cmd)
            rvTypes::ALU_ADD:
                result = a + b;
            rvTypes::ALU_SUB:
                result = a - b;
            rvTypes::ALU_SLL:
                result = a << shamt;
            rvTypes::ALU_SLT:
                result = {31'b0, $signed(a) < $signed(b)};
            rvTypes::ALU_SLTU:
                result = {31'b0, a < b};
            rvTypes::ALU_XOR:
                result = a ^ b;
            rvTypes::ALU_SRL:
                result = a >> shamt;
            rvTypes::ALU_SRA:
                result = $unsigned($signed(a) >>> shamt);  // sign bit fills in
            rvTypes::ALU_OR:
                result = a | b;
            rvTypes::ALU_AND:
                result = a & b;
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/pcUnit.sv
`default_nettype none
`timescale 1ns/1ns
`include "rvCore_cfg.svh"

module pcUnit (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire                       advance,
    input  wire rvTypes::DecodedInstr dec,
    input  wire logic [31:0]          rs1Data,
    input  wire logic [31:0]          rs2Data,
    output logic [31:0]               pc,
    output logic [31:0]               nextPc,
    output logic [31:0]               linkPc
);

    logic        taken;
    logic [31:0] target;

    always_comb begin
        case (dec.branchCond)
            rvTypes::BEQ:  taken = (rs1Data == rs2Data);
            rvTypes::BNE:  taken = (rs1Data != rs2Data);
            rvTypes::BLT:  taken = ($signed(rs1Data) < $signed(rs2Data));
            rvTypes::BGE:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            rvTypes::BLTU: taken = (rs1Data < rs2Data);
            rvTypes::BGEU: taken = (rs1Data >= rs2Data);
            default:       taken = 1'b0;  // funct3 010/011 never branch
        endcase
    end

    always_comb begin
        case (dec.opCode)
            rvTypes::BRANCH: target = taken ? pc + dec.imm : linkPc;
            rvTypes::JAL:    target = pc + dec.imm;
            rvTypes::JALR:   target = rs1Data + dec.imm;
            default:         target = linkPc;
        endcase
    end

    assign linkPc = pc + 32'd4;
    assign nextPc = {target[31:2], 2'b00};  // no misaligned targets

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`default_nettype none
`timescale 1ns/1ns
`include "rvCore_cfg.svh"

module regFile (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire rvTypes::RegAddr rdAddrA,
    input  wire rvTypes::RegAddr rdAddrB,
    output logic [31:0]          rdDataA,
    output logic [31:0]          rdDataB,
    input  wire                  wrEn,
    input  wire rvTypes::RegAddr wrAddr,
    input  wire logic [31:0]     wrData
);

    logic [31:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin  // x0 never written
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    // x0 stays zero across all writes since reset
    assert property (@(posedge clk) disable iff (!rstN) (rdAddrA == '0) |-> (rdDataA == '0));
    assert property (@(posedge clk) disable iff (!rstN) (rdAddrB == '0) |-> (rdDataB == '0));

endmodule

`default_nettype wire

// File: verilog/rvCore.sv
`default_nettype none
`timescale 1ns/1ns

module rvCore (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire                      instrValid,
    input  wire rvTypes::Instruction instr,
    output logic [31:0]              pc,
    output logic                     retireValid,
    output rvTypes::RetireInfo       retire
);

    rvTypes::DecodedInstr dec;
    rvTypes::RetireInfo   record;
    logic [31:0]          rs1Data;
    logic [31:0]          rs2Data;
    logic [31:0]          aluB;
    logic [31:0]          aluResult;
    logic [31:0]          nextPc;
    logic [31:0]          linkPc;
    logic [31:0]          wbData;
    logic                 wbWrite;

    instrDecoder u_decoder (.instr(instr), .dec(dec));

    regFile u_regFile (
        .clk(clk), .rstN(rstN),
        .rdAddrA(dec.rs1), .rdAddrB(dec.rs2),
        .rdDataA(rs1Data), .rdDataB(rs2Data),
        .wrEn(wbWrite), .wrAddr(dec.rd), .wrData(wbData)
    );

    assign aluB = dec.useImm ? dec.imm : rs2Data;

    intAlu u_alu (.cmd(dec.aluCmd), .a(rs1Data), .b(aluB), .result(aluResult));

    pcUnit u_pcUnit (
        .clk(clk), .rstN(rstN), .advance(instrValid), .dec(dec),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .pc(pc), .nextPc(nextPc), .linkPc(linkPc)
    );

    always_comb begin
        case (dec.opCode)
            rvTypes::OP, rvTypes::OP_IMM: wbData = aluResult;
            rvTypes::LUI:                 wbData = dec.imm;
            rvTypes::AUIPC:               wbData = pc + dec.imm;
            rvTypes::JAL, rvTypes::JALR:  wbData = linkPc;  // return address
            default:                      wbData = '0;
        endcase
    end

    assign wbWrite = instrValid && dec.wbEn;

    always_comb begin
        record.pc      = pc;
        record.instr   = instr;
        record.wbEn    = dec.wbEn;
        record.wbAddr  = dec.rd;
        record.wbData  = wbData;
        record.nextPc  = nextPc;
        record.illegal = dec.illegal;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireValid <= 1'b0;
            retire      <= '0;
        end else begin
            retireValid <= instrValid;  // one record per accepted instruction
            if (instrValid) begin
                retire <= record;
            end
        end
    end

    // an illegal instruction falls through to the next word
    assert property (@(posedge clk) disable iff (!rstN)
        (retireValid && retire.illegal) |-> (retire.nextPc == retire.pc + 32'd4));
    // the PC register and the retired record agree on the target
    assert property (@(posedge clk) disable iff (!rstN) retireValid |-> (pc == retire.nextPc));

endmodule

`default_nettype wire

// File: verilog/rvCore_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// first fetch address, must be word aligned
`define RV_RESET_PC 32'h0000_0000

// architectural integer registers
`define RV_REG_COUNT 32

`endif

// File: verilog/rvTypes.sv
`default_nettype none

package rvTypes;

    // major opcode, bits 6:2 of the instruction word
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    typedef logic [4:0] RegAddr;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } AluCmd;

    // same values as funct3 of a branch
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } BranchCond;

    // R-type field layout, immediates are cut from these fields
    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
        OpCode      opCode;
        logic [1:0] always11;  // 2'b11 for 32-bit encodings
    } Instruction;

    typedef struct packed {
        OpCode       opCode;
        RegAddr      rs1;
        RegAddr      rs2;
        RegAddr      rd;
        AluCmd       aluCmd;
        logic        useImm;      // imm replaces rs2 as operand b
        logic [31:0] imm;         // sign extended
        BranchCond   branchCond;
        logic        wbEn;
        logic        illegal;
    } DecodedInstr;

    typedef struct packed {
        logic [31:0] pc;
        Instruction  instr;
        logic        wbEn;
        RegAddr      wbAddr;
        logic [31:0] wbData;
        logic [31:0] nextPc;
        logic        illegal;
    } RetireInfo;

endpackage

`default_nettype wire
